//--- source/cp0_pkg.sv
package cp0_pkg;

    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        CONFIG   = 5'd16
    } cp0_number_t;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    localparam logic [31:0] STATUS_RESET = 32'h0040_0000; // BEV set, interrupts off.
    localparam logic [31:0] CONFIG_RESET = 32'h8000_0003;

    localparam logic [31:0] STATUS_WMASK = 32'h0000_ff03; // IM, EXL, IE.
    localparam logic [31:0] CAUSE_WMASK  = 32'h0000_0300; // Software IP[1:0].
    localparam logic [31:0] CONFIG_WMASK = 32'h0000_0007; // K0.

    localparam logic [31:0] EXC_VECTOR_BEV    = 32'hbfc0_0380;
    localparam logic [31:0] EXC_VECTOR_NORMAL = 32'h8000_0180;

    localparam int STATUS_BEV = 22;
    localparam int STATUS_EXL = 1;
    localparam int STATUS_IE  = 0;
    localparam int CAUSE_BD   = 31;
    localparam int CAUSE_TI   = 30;

    localparam logic [2:0] K0_CACHED = 3'd3; // Cacheable, noncoherent.

    function automatic logic [31:0] masked_merge(input logic [31:0] old_value,
                                                 input logic [31:0] new_value,
                                                 input logic [31:0] mask);
        return (old_value & ~mask) | (new_value & mask);
    endfunction

endpackage

//--- source/mem_map_pkg.sv
package mem_map_pkg;

    typedef logic [31:0] word;

    // Decoded from vaddr[31:29].
    typedef enum logic [1:0] {
        KUSEG  = 2'd0,
        KSEG0  = 2'd1,
        KSEG1  = 2'd2,
        KSEG23 = 2'd3
    } segment_t;

    localparam word KSEG0_BASE  = 32'h8000_0000;
    localparam word KSEG1_BASE  = 32'ha000_0000;
    localparam word KSEG23_BASE = 32'hc000_0000;

    localparam word KUSEG_OFFSET    = 32'h4000_0000;
    localparam word SEG_OFFSET_MASK = 32'h1fff_ffff; // Strips the segment bits.

    function automatic segment_t segment_of(input word vaddr);
        if (vaddr[31:29] < KSEG0_BASE[31:29]) begin
            return KUSEG;
        end else if (vaddr[31:29] < KSEG1_BASE[31:29]) begin
            return KSEG0;
        end else if (vaddr[31:29] < KSEG23_BASE[31:29]) begin
            return KSEG1;
        end
        return KSEG23;
    endfunction

endpackage

//--- source/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch #(
    parameter int RESET_HOLD_CYCLES = 16
) (
    input  logic aclk,
    input  logic global_reset,
    output logic o_core_reset
);

    localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;

    // Counter saturates at the hold length, so the core stays released.
    always_ff @(posedge aclk) begin
        if (global_reset) begin
            hold_cnt     <= '0;
            o_core_reset <= 1'b1;
        end else if (hold_cnt != CNT_W'(RESET_HOLD_CYCLES)) begin
            hold_cnt     <= hold_cnt + 1'b1;
            o_core_reset <= (hold_cnt != CNT_W'(RESET_HOLD_CYCLES - 1)); // Last edge.
        end
    end

endmodule

//--- source/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs
    import cp0_pkg::*;
    import mem_map_pkg::*;
(
    input  logic        aclk,
    input  logic        i_reset,

    input  logic        i_we,
    input  cp0_number_t i_rw_number,
    input  word         i_wdata,
    output word         o_rdata,

    input  logic        i_exc_en,
    input  logic        i_exc_bd,
    input  exc_code_t   i_exc_code,
    input  word         i_exc_epc,
    input  word         i_exc_badvaddr,
    input  logic        i_eret,

    input  logic [4:0]  i_hw_int,

    output word         o_epc,
    output word         o_exc_handler,
    output logic        o_interrupt_pending,
    output logic        o_kseg0_cached
);

    word status_q, cause_q, epc_q, badvaddr_q, count_q, compare_q, config_q;
    word status_d, cause_d, epc_d, badvaddr_d, count_d, compare_d, config_d;

    always_comb begin
        status_d   = status_q;
        cause_d    = cause_q;
        epc_d      = epc_q;
        badvaddr_d = badvaddr_q;
        count_d    = count_q + 32'd1;
        compare_d  = compare_q;
        config_d   = config_q;

        if (count_q == compare_q) begin
            cause_d[CAUSE_TI] = 1'b1; // Timer match.
        end

        if (i_exc_en) begin
            if (!status_q[STATUS_EXL]) begin // Nested exceptions keep the first EPC.
                epc_d             = i_exc_epc;
                cause_d[CAUSE_BD] = i_exc_bd;
            end
            cause_d[6:2] = i_exc_code;
            if ((i_exc_code == ADEL) || (i_exc_code == ADES)) begin
                badvaddr_d = i_exc_badvaddr;
            end
            status_d[STATUS_EXL] = 1'b1;
        end else if (i_eret) begin
            status_d[STATUS_EXL] = 1'b0;
        end else if (i_we) begin
            case (i_rw_number)
                STATUS:  status_d = masked_merge(status_q, i_wdata, STATUS_WMASK);
                CAUSE:   cause_d = masked_merge(cause_d, i_wdata, CAUSE_WMASK);
                EPC:     epc_d = i_wdata;
                COUNT:   count_d = i_wdata;
                COMPARE: begin
                    compare_d         = i_wdata;
                    cause_d[CAUSE_TI] = 1'b0; // Acknowledges the timer.
                end
                CONFIG:  config_d = masked_merge(config_q, i_wdata, CONFIG_WMASK);
                default: ;
            endcase
        end

        cause_d[14:10] = i_hw_int;          // IP[6:2].
        cause_d[15]    = cause_d[CAUSE_TI]; // IP7.
    end

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            status_q   <= STATUS_RESET;
            cause_q    <= '0;
            epc_q      <= '0;
            badvaddr_q <= '0;
            count_q    <= '0;
            compare_q  <= '0;
            config_q   <= CONFIG_RESET;
        end else begin
            status_q   <= status_d;
            cause_q    <= cause_d;
            epc_q      <= epc_d;
            badvaddr_q <= badvaddr_d;
            count_q    <= count_d;
            compare_q  <= compare_d;
            config_q   <= config_d;
        end
    end

    always_comb begin
        case (i_rw_number)
            BADVADDR: o_rdata = badvaddr_q;
            COUNT:    o_rdata = count_q;
            COMPARE:  o_rdata = compare_q;
            STATUS:   o_rdata = status_q;
            CAUSE:    o_rdata = cause_q;
            EPC:      o_rdata = epc_q;
            CONFIG:   o_rdata = config_q;
            default:  o_rdata = '0; // Unimplemented registers read as zero.
        endcase
    end

    assign o_epc         = epc_q;
    assign o_exc_handler = status_q[STATUS_BEV] ? EXC_VECTOR_BEV : EXC_VECTOR_NORMAL;

    // IP masked by IM, gated by IE and EXL.
    assign o_interrupt_pending = status_q[STATUS_IE] && !status_q[STATUS_EXL]
                                 && (|(cause_q[15:8] & status_q[15:8]));

    assign o_kseg0_cached = (config_q[2:0] == K0_CACHED);

endmodule

//--- source/addr_translate.sv
`timescale 1ns/1ps

module addr_translate
    import mem_map_pkg::*;
(
    input  logic aclk,
    input  logic i_reset,
    input  logic i_kseg0_cached,

    input  logic i_i_req,
    input  word  i_i_vaddr,
    output logic o_i_valid,
    output word  o_i_paddr,
    output logic o_i_cached,

    input  logic i_d_req,
    input  word  i_d_vaddr,
    output logic o_d_valid,
    output word  o_d_paddr,
    output logic o_d_cached
);

    segment_t i_seg, d_seg;

    function automatic word phys_addr(input word vaddr, input segment_t seg);
        case (seg)
            KUSEG:   return vaddr + KUSEG_OFFSET;
            KSEG0,
            KSEG1:   return vaddr & SEG_OFFSET_MASK;
            default: return vaddr; // kseg2/3 map straight through.
        endcase
    endfunction

    // Only kseg1 ignores the K0 policy.
    function automatic logic phys_cached(input segment_t seg, input logic k0_cached);
        return (seg == KSEG1) ? 1'b0 : k0_cached;
    endfunction

    assign i_seg = segment_of(i_i_vaddr);
    assign d_seg = segment_of(i_d_vaddr);

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            o_i_valid <= 1'b0;
            o_d_valid <= 1'b0;
        end else begin
            o_i_valid <= i_i_req; // One-cycle pulse per request.
            o_d_valid <= i_d_req;
        end
    end

    // Results hold until the next request on the same path.
    always_ff @(posedge aclk) begin
        if (i_i_req) begin
            o_i_paddr  <= phys_addr(i_i_vaddr, i_seg);
            o_i_cached <= phys_cached(i_seg, i_kseg0_cached);
        end
        if (i_d_req) begin
            o_d_paddr  <= phys_addr(i_d_vaddr, d_seg);
            o_d_cached <= phys_cached(d_seg, i_kseg0_cached);
        end
    end

endmodule

//--- source/sys_ctrl_top.sv
`timescale 1ns/1ps

module sys_ctrl_top
    import cp0_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int RESET_HOLD_CYCLES = 16
) (
    input  logic        aclk,
    input  logic        global_reset,
    output logic        o_core_reset,

    input  logic        i_we,
    input  cp0_number_t i_rw_number,
    input  word         i_wdata,
    output word         o_rdata,
    input  logic        i_exc_en,
    input  logic        i_exc_bd,
    input  exc_code_t   i_exc_code,
    input  word         i_exc_epc,
    input  word         i_exc_badvaddr,
    input  logic        i_eret,
    input  logic [4:0]  i_hw_int,
    output word         o_epc,
    output word         o_exc_handler,
    output logic        o_interrupt_pending,

    input  logic        i_i_req,
    input  word         i_i_vaddr,
    output logic        o_i_valid,
    output word         o_i_paddr,
    output logic        o_i_cached,
    input  logic        i_d_req,
    input  word         i_d_vaddr,
    output logic        o_d_valid,
    output word         o_d_paddr,
    output logic        o_d_cached
);

    logic w_core_reset;
    logic w_kseg0_cached;

    assign o_core_reset = w_core_reset;

    reset_stretch #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) u_reset_stretch (
        .aclk         (aclk),
        .global_reset (global_reset),
        .o_core_reset (w_core_reset)
    );

    cp0_regs u_cp0_regs (
        .aclk                (aclk),
        .i_reset             (w_core_reset),
        .i_we                (i_we),
        .i_rw_number         (i_rw_number),
        .i_wdata             (i_wdata),
        .o_rdata             (o_rdata),
        .i_exc_en            (i_exc_en),
        .i_exc_bd            (i_exc_bd),
        .i_exc_code          (i_exc_code),
        .i_exc_epc           (i_exc_epc),
        .i_exc_badvaddr      (i_exc_badvaddr),
        .i_eret              (i_eret),
        .i_hw_int            (i_hw_int),
        .o_epc               (o_epc),
        .o_exc_handler       (o_exc_handler),
        .o_interrupt_pending (o_interrupt_pending),
        .o_kseg0_cached      (w_kseg0_cached)
    );

    addr_translate u_addr_translate (
        .aclk           (aclk),
        .i_reset        (w_core_reset),
        .i_kseg0_cached (w_kseg0_cached), // Config.K0 steers kseg0 and the mapped segments.
        .i_i_req        (i_i_req),
        .i_i_vaddr      (i_i_vaddr),
        .o_i_valid      (o_i_valid),
        .o_i_paddr      (o_i_paddr),
        .o_i_cached     (o_i_cached),
        .i_d_req        (i_d_req),
        .i_d_vaddr      (i_d_vaddr),
        .o_d_valid      (o_d_valid),
        .o_d_paddr      (o_d_paddr),
        .o_d_cached     (o_d_cached)
    );

endmodule

//--- verification/sys_ctrl_model.svh
`ifndef SYS_CTRL_MODEL_SVH
`define SYS_CTRL_MODEL_SVH

word  m_status, m_cause, m_epc, m_badvaddr, m_count, m_compare, m_config;
logic m_rst = 1'b1;
int   m_low_edges = 0;
logic m_i_valid, m_i_cached, m_d_valid, m_d_cached;
word  m_i_paddr, m_d_paddr;

function automatic word merge_bits(input word old_v, input word new_v, input word mask);
    return (old_v & ~mask) | (new_v & mask);
endfunction

function automatic word map_paddr(input word va);
    case (va[31:29])
        3'd4, 3'd5: return {3'b000, va[28:0]}; // kseg0 and kseg1.
        3'd6, 3'd7: return va;
        default:    return va + 32'h4000_0000;
    endcase
endfunction

function automatic logic map_cached(input word va, input word cfg);
    return (va[31:29] == 3'd5) ? 1'b0 : (cfg[2:0] == 3'd3);
endfunction

function automatic word exp_rdata(input logic [4:0] num);
    case (num)
        5'd8:    return m_badvaddr;
        5'd9:    return m_count;
        5'd11:   return m_compare;
        5'd12:   return m_status;
        5'd13:   return m_cause;
        5'd14:   return m_epc;
        5'd16:   return m_config;
        default: return 32'h0;
    endcase
endfunction

function automatic logic exp_pending();
    return m_status[0] && !m_status[1] && (|(m_cause[15:8] & m_status[15:8]));
endfunction

`endif

//--- verification/sys_ctrl_tb.sv
`timescale 1ns/1ps

module sys_ctrl_tb;
    import cp0_pkg::*;
    import mem_map_pkg::*;

    localparam int RESET_HOLD_CYCLES = 16;
    localparam int TOTAL_CYCLES = 20 + 600 + 300 + 300 + 200; // Upper bound over all tests.

    logic aclk = 1'b0, global_reset, o_core_reset;
    logic i_we, i_exc_en, i_exc_bd, i_eret, i_i_req, i_d_req;
    cp0_number_t i_rw_number;
    exc_code_t   i_exc_code;
    word  i_wdata, i_exc_epc, i_exc_badvaddr, i_i_vaddr, i_d_vaddr;
    logic [4:0] i_hw_int;
    word  o_rdata, o_epc, o_exc_handler, o_i_paddr, o_d_paddr;
    logic o_interrupt_pending, o_i_valid, o_i_cached, o_d_valid, o_d_cached;

    integer seed = 32'h4ff5;
    int errors = 0;
    int test_start;
    logic checks_on = 1'b0;
    exc_code_t codes [7] = '{INT, ADEL, ADES, SYS, BP, RI, OV};

    `include "sys_ctrl_model.svh"

    sys_ctrl_top #(.RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)) DUT (.*);

    initial begin
        forever #4 aclk = ~aclk;
    end

    initial begin
        #((3 + 16 + TOTAL_CYCLES) * 8 * 2);
        $display("Watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

    function automatic word rand_word();
        return $random(seed);
    endfunction

    task automatic check_word(input string name, input word got, input word exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        check_word("o_core_reset", {31'b0, o_core_reset}, {31'b0, m_rst});
        check_word("o_rdata", o_rdata, exp_rdata(i_rw_number));
        check_word("o_epc", o_epc, m_epc);
        check_word("o_exc_handler", o_exc_handler,
                   m_status[22] ? 32'hbfc0_0380 : 32'h8000_0180);
        check_word("o_interrupt_pending", {31'b0, o_interrupt_pending}, {31'b0, exp_pending()});
        check_word("o_i_valid", {31'b0, o_i_valid}, {31'b0, m_i_valid});
        check_word("o_d_valid", {31'b0, o_d_valid}, {31'b0, m_d_valid});
        if (m_i_valid) begin
            check_word("o_i_paddr", o_i_paddr, m_i_paddr);
            check_word("o_i_cached", {31'b0, o_i_cached}, {31'b0, m_i_cached});
        end
        if (m_d_valid) begin
            check_word("o_d_paddr", o_d_paddr, m_d_paddr);
            check_word("o_d_cached", {31'b0, o_d_cached}, {31'b0, m_d_cached});
        end
    endtask

    // Next state from the pre-edge model state and the inputs of this cycle.
    task automatic model_advance();
        word cause_n;
        // Translation sees the K0 value held before this edge.
        if (i_i_req) begin
            m_i_paddr = map_paddr(i_i_vaddr);
            m_i_cached = map_cached(i_i_vaddr, m_config);
        end
        if (i_d_req) begin
            m_d_paddr = map_paddr(i_d_vaddr);
            m_d_cached = map_cached(i_d_vaddr, m_config);
        end
        if (m_rst) begin
            m_status = 32'h0040_0000;
            m_config = 32'h8000_0003;
            {m_cause, m_epc, m_badvaddr, m_count, m_compare} = '0;
        end else begin
            cause_n = m_cause;
            if (m_count == m_compare) cause_n[30] = 1'b1;
            m_count = m_count + 1;
            if (i_exc_en) begin
                if (!m_status[1]) begin
                    m_epc = i_exc_epc;
                    cause_n[31] = i_exc_bd;
                end
                cause_n[6:2] = i_exc_code;
                if (i_exc_code == ADEL || i_exc_code == ADES) m_badvaddr = i_exc_badvaddr;
                m_status[1] = 1'b1;
            end else if (i_eret) begin
                m_status[1] = 1'b0;
            end else if (i_we) begin
                case (i_rw_number)
                    STATUS:  m_status = merge_bits(m_status, i_wdata, 32'h0000_ff03);
                    CAUSE:   cause_n = merge_bits(cause_n, i_wdata, 32'h0000_0300);
                    EPC:     m_epc = i_wdata;
                    COUNT:   m_count = i_wdata;
                    CONFIG:  m_config = merge_bits(m_config, i_wdata, 32'h0000_0007);
                    COMPARE: begin
                        m_compare = i_wdata;
                        cause_n[30] = 1'b0;
                    end
                    default: ;
                endcase
            end
            cause_n[14:10] = i_hw_int;
            cause_n[15] = cause_n[30]; // Timer shows as IP7.
            m_cause = cause_n;
        end
        m_i_valid = !m_rst && i_i_req;
        m_d_valid = !m_rst && i_d_req;
        if (global_reset) m_low_edges = 0;
        else if (m_low_edges < RESET_HOLD_CYCLES) m_low_edges++;
        m_rst = global_reset || (m_low_edges < RESET_HOLD_CYCLES);
    endtask

    task automatic cycle();
        @(negedge aclk);
        if (checks_on) compare_outputs();
        model_advance();
        @(posedge aclk);
        #1;
        {i_we, i_exc_en, i_eret, i_i_req, i_d_req} = '0; // Strobes last one cycle.
    endtask

    task automatic mtc0(input cp0_number_t num, input word data);
        i_we = 1'b1;
        i_rw_number = num;
        i_wdata = data;
    endtask

    task automatic report(input string name);
        $display("%s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin : main
        word r;
        int n;
        int reqs;
        int excs;
        global_reset = 1'b1;
        {i_we, i_exc_en, i_exc_bd, i_eret, i_i_req, i_d_req} = '0;
        i_rw_number = STATUS;
        i_exc_code = INT;
        {i_wdata, i_exc_epc, i_exc_badvaddr, i_i_vaddr, i_d_vaddr} = '0;
        i_hw_int = '0;
        test_start = 0;

        repeat (3) cycle();
        global_reset = 1'b0;
        checks_on = 1'b1;
        n = 0;
        while (n < 40) begin
            cycle();
            n++;
            if (!o_core_reset) break;
        end
        assert (n == RESET_HOLD_CYCLES) else begin
            $display("Core reset released after %0d edges instead of %0d", n, RESET_HOLD_CYCLES);
            errors++;
        end
        i_rw_number = COUNT;
        #1;
        check_word("count at release", o_rdata, 32'h0);
        check_word("valid at release", {30'b0, o_i_valid, o_d_valid}, 32'h0);
        check_word("pending at release", {31'b0, o_interrupt_pending}, 32'h0);
        repeat (4) cycle();
        report("test 1 reset stretch");

        repeat (300) begin
            r = rand_word();
            mtc0(cp0_number_t'(r[4:0]), rand_word());
            cycle();
            i_rw_number = cp0_number_t'(r[4:0]);
            cycle();
        end
        report("test 2 mtc0 readback");

        reqs = 0;
        while (reqs < 300) begin
            r = rand_word();
            if (r[3:0] == 4'd0) mtc0(CONFIG, rand_word()); // K0 changes now and then.
            i_i_req = r[4] || !r[5];
            i_d_req = r[5];
            i_i_vaddr = rand_word();
            i_d_vaddr = rand_word();
            reqs += int'(i_i_req) + int'(i_d_req);
            cycle();
        end
        report("test 3 address translation");

        i_rw_number = CAUSE;
        excs = 0;
        while (excs < 100) begin
            r = rand_word();
            if (r[1:0] == 2'd0) begin
                mtc0(STATUS, rand_word()); // Random EXL state.
                cycle();
                i_rw_number = CAUSE;
            end
            i_exc_en = 1'b1;
            i_exc_bd = r[2];
            i_exc_code = codes[r[10:8] % 7];
            i_exc_epc = rand_word();
            i_exc_badvaddr = rand_word();
            i_eret = r[3];
            i_rw_number = r[4] ? EPC : (r[5] ? BADVADDR : CAUSE);
            excs++;
            cycle();
            if (r[7:6] == 2'd0) begin
                i_eret = 1'b1;
                i_rw_number = STATUS;
                cycle();
            end
        end
        report("test 4 exceptions");

        repeat (200) begin
            r = rand_word();
            i_hw_int = r[4:0];
            case (r[9:8])
                2'd0:    mtc0(STATUS, rand_word());
                2'd1:    mtc0(COMPARE, m_count + 32'd2 + {29'b0, r[12:10]});
                default: i_rw_number = CAUSE;
            endcase
            cycle();
        end
        report("test 5 interrupts and timer");

        $display("Total errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verification
source/cp0_pkg.sv
source/mem_map_pkg.sv
source/reset_stretch.sv
source/cp0_regs.sv
source/addr_translate.sv
source/sys_ctrl_top.sv
verification/sys_ctrl_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module sys_ctrl_tb -o sys_ctrl_sim
./obj_dir/sys_ctrl_sim > sim.log 2>&1
cat sim.log

if grep -q "\*\* PASS \*\*" sim.log; then
    exit 0
fi
exit 1
